/* sim/mdio_cases.txt */
// op (1 write, 0 read, F ends the list), PHY address, register, write data,
// expected read data, expected error flag. The model sits at PHY 3.
0 03 02 0000 0002 0
1 03 02 A5C3 0000 0
0 03 02 0000 A5C3 0
0 07 02 0000 FFFF 1
1 03 1F 1234 0000 0
0 03 1F 0000 1234 0
0 03 00 0000 0000 0
0 03 1E 0000 001E 0
1 03 00 FFFF 0000 0
0 03 00 0000 FFFF 0
1 03 10 0001 0000 0
0 03 10 0000 0001 0
1 05 04 BEEF 0000 0
0 03 04 0000 0004 0
0 00 04 0000 FFFF 1
0 1F 1F 0000 FFFF 1
1 03 04 8000 0000 0
0 03 04 0000 8000 0
1 03 05 0000 0000 0
0 03 05 0000 0000 0
1 03 1F 5A5A 0000 0
0 03 1F 0000 5A5A 0
0 02 01 0000 FFFF 1
0 03 01 0000 0001 0
0 03 02 0000 A5C3 0
0 04 02 0000 FFFF 1
F 00 00 0000 0000 0

/* project.f */
rtl/mdio_pkg.sv
rtl/mdio_frame_decode.sv
rtl/mdio_frame_engine.sv
rtl/mdio_read_result.sv
rtl/mdio_sta.sv
sim/mdio_phy_model.sv
sim/tb_mdio_sta.sv

/* run.sh */
#!/bin/sh
# Build and run the MDIO station testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_mdio_sta \
	--Mdir "$BUILD_DIR" -o tb_mdio_sta \
	-f project.f

"$BUILD_DIR/tb_mdio_sta" | tee "$LOG"

if grep -qx "Test passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* sim/tb_mdio_sta.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mdio_sta;

	localparam int CLK_DIV = 4;
	localparam int PREAMBLE_BITS = 32;
	localparam int PHY_ADDR = 3;
	localparam int MAX_CASES = 32;
	localparam int CLK_NS = 40;
	localparam int RESET_CYCLES = 16;
	// One whole access in core_clk cycles
	localparam int FRAME_CYCLES = (PREAMBLE_BITS + 32) * 2 * CLK_DIV;

	logic core_clk;
	logic rst_n;
	logic cmd_req;
	logic cmd_write;
	logic [mdio_pkg::ADDR_W-1:0] cmd_phy_addr;
	logic [mdio_pkg::ADDR_W-1:0] cmd_reg_addr;
	logic [mdio_pkg::DATA_W-1:0] cmd_wdata;
	logic cmd_ack;
	logic [mdio_pkg::DATA_W-1:0] rsp_rdata;
	logic rsp_error;
	logic mdc;
	logic mdio_out;
	logic mdio_oe;
	wire mdio_in;
	wire proto_error;
	wire [7:0] frame_count;

	// Six fields per case as laid out in the data file
	logic [15:0] case_mem [0:6*MAX_CASES-1];
	int n_cases = 0;
	logic [15:0] lfsr_state;

	mdio_sta #(
		.CLK_DIV       (CLK_DIV),
		.PREAMBLE_BITS (PREAMBLE_BITS)
	) DUT (
		.core_clk     (core_clk),
		.rst_n        (rst_n),
		.cmd_req      (cmd_req),
		.cmd_write    (cmd_write),
		.cmd_phy_addr (cmd_phy_addr),
		.cmd_reg_addr (cmd_reg_addr),
		.cmd_wdata    (cmd_wdata),
		.cmd_ack      (cmd_ack),
		.rsp_rdata    (rsp_rdata),
		.rsp_error    (rsp_error),
		.mdc          (mdc),
		.mdio_out     (mdio_out),
		.mdio_oe      (mdio_oe),
		.mdio_in      (mdio_in)
	);

	mdio_phy_model #(
		.PHY_ADDR      (PHY_ADDR),
		.PREAMBLE_BITS (PREAMBLE_BITS)
	) u_phy (
		.mdc          (mdc),
		.mdio_out     (mdio_out),
		.mdio_oe      (mdio_oe),
		.mdio_in      (mdio_in),
		.exp_write    (cmd_write),
		.exp_phy_addr (cmd_phy_addr),
		.exp_reg_addr (cmd_reg_addr),
		.proto_error  (proto_error),
		.frame_count  (frame_count)
	);

	initial begin
		core_clk = 1'b0;
		forever #(CLK_NS / 2) core_clk = ~core_clk;
	end

	////////////////////
	// Helpers

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			stop_run("checked value differs");
		end
	endtask

	// Settle past the edge before sampling and driving
	task automatic next_cycle();
		@(posedge core_clk);
		#2;
	endtask

	// 16-bit Fibonacci with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One step per bit taken
	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	always @(posedge proto_error)
		stop_run("PHY model rejected a frame on the bus");

	////////////////////
	// Stimulus

	initial begin
		int base;
		int gap;
		int hold;
		int waited;
		logic [15:0] exp_rdata;
		logic exp_error;
		logic [15:0] held_rdata;
		logic held_error;
		logic [7:0] frames_before;

		rst_n = 1'b0;
		cmd_req = 1'b0;
		cmd_write = 1'b0;
		cmd_phy_addr = '0;
		cmd_reg_addr = '0;
		cmd_wdata = '0;
		lfsr_state = 16'd17;

		$readmemh("sim/mdio_cases.txt", case_mem);
		// F in the op column ends the list
		while (n_cases < MAX_CASES && case_mem[6 * n_cases] != 16'hF)
			n_cases++;
		if (n_cases == 0)
			stop_run("no cases read from sim/mdio_cases.txt");

		repeat (RESET_CYCLES) @(posedge core_clk);
		#2;
		rst_n = 1'b1;
		next_cycle();

		// Quiet bus before the first request
		check_value("reset mdc", 32'd0, 32'(mdc));
		check_value("reset mdio_oe", 32'd0, 32'(mdio_oe));
		check_value("reset cmd_ack", 32'd0, 32'(cmd_ack));
		check_value("reset rsp_error", 32'd0, 32'(rsp_error));

		for (int c = 0; c < n_cases; c++) begin
			base = 6 * c;
			exp_rdata = case_mem[base + 4];
			exp_error = case_mem[base + 5][0];
			frames_before = frame_count;

			// Idle gap without MDC activity
			draw_bits(4, gap);
			repeat (gap) begin
				next_cycle();
				check_value($sformatf("case %0d idle mdc", c), 32'd0, 32'(mdc));
			end

			cmd_write = case_mem[base][0];
			cmd_phy_addr = case_mem[base + 1][mdio_pkg::ADDR_W-1:0];
			cmd_reg_addr = case_mem[base + 2][mdio_pkg::ADDR_W-1:0];
			cmd_wdata = case_mem[base + 3];
			cmd_req = 1'b1;

			waited = 0;
			while (!cmd_ack) begin
				if (waited >= FRAME_CYCLES + 4)
					stop_run($sformatf("case %0d got no cmd_ack within %0d cycles",
						c, FRAME_CYCLES + 4));
				next_cycle();
				waited++;
			end

			check_value($sformatf("case %0d rsp_rdata", c), 32'(exp_rdata), 32'(rsp_rdata));
			check_value($sformatf("case %0d rsp_error", c), 32'(exp_error), 32'(rsp_error));
			check_value($sformatf("case %0d frames on bus", c),
				32'(frames_before + 8'd1), 32'(frame_count));

			// Response stays put while the host holds req
			held_rdata = rsp_rdata;
			held_error = rsp_error;
			draw_bits(3, hold);
			repeat (hold) begin
				next_cycle();
				check_value($sformatf("case %0d held ack", c), 32'd1, 32'(cmd_ack));
				check_value($sformatf("case %0d held rdata", c),
					32'(held_rdata), 32'(rsp_rdata));
				check_value($sformatf("case %0d held error", c),
					32'(held_error), 32'(rsp_error));
				check_value($sformatf("case %0d held mdc", c), 32'd0, 32'(mdc));
			end

			cmd_req = 1'b0;
			waited = 0;
			while (cmd_ack) begin
				if (waited >= 4)
					stop_run($sformatf("case %0d kept cmd_ack high after cmd_req fell", c));
				next_cycle();
				waited++;
			end
		end

		repeat (4) next_cycle();
		$display("Test passed");
		$finish;
	end

	////////////////////
	// Watchdog

	initial begin
		longint limit_ns;
		// Case count is settled once reset is released
		@(posedge rst_n);
		// Twice the nominal frame time per case after the reset time
		limit_ns = longint'(n_cases) * FRAME_CYCLES * CLK_NS * 2;
		#(limit_ns);
		stop_run($sformatf("watchdog expired %0d ns after reset", limit_ns));
	end

endmodule

`default_nettype wire

/* sim/mdio_phy_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_phy_model #(
	parameter int PHY_ADDR = 3,
	parameter int PREAMBLE_BITS = 32
) (
	// Station side of the bus
	input wire mdc,
	input wire mdio_out,
	input wire mdio_oe,
	// Resolved line back to the station
	output wire mdio_in,

	// Fields the running case should put on the bus
	input wire exp_write,
	input wire [mdio_pkg::ADDR_W-1:0] exp_phy_addr,
	input wire [mdio_pkg::ADDR_W-1:0] exp_reg_addr,

	output wire proto_error,
	output wire [7:0] frame_count
);

	localparam logic [mdio_pkg::ADDR_W-1:0] MY_ADDR = PHY_ADDR[mdio_pkg::ADDR_W-1:0];

	// Unwritten registers read back their own index
	logic [mdio_pkg::DATA_W-1:0] regs [0:31];
	logic [31:0] written = '0;
	// Ones since the last frame
	int ones = 0;
	// Frame bits taken so far or zero while hunting for the start code
	int fidx = 0;
	logic [31:0] rx = '0;
	logic [1:0] rx_op = '0;
	logic [mdio_pkg::ADDR_W-1:0] rx_phy = '0;
	logic [mdio_pkg::ADDR_W-1:0] rx_reg = '0;
	logic reading = 1'b0;
	logic err_flag = 1'b0;
	logic [7:0] frames = '0;
	logic phy_oe = 1'b0;
	logic phy_out = 1'b1;
	logic [mdio_pkg::DATA_W-1:0] tx = '0;

	// Station first, then this PHY, else the pull-up
	assign mdio_in = mdio_oe ? mdio_out : (phy_oe ? phy_out : 1'b1);
	assign proto_error = err_flag;
	assign frame_count = frames;

	task automatic flag(input string what);
		$display("PHY model: %s", what);
		err_flag = 1'b1;
	endtask

	////////////////////
	// Receive on MDC rising edges

	always @(posedge mdc) begin
		if (fidx == 0) begin
			if (mdio_in) begin
				ones = ones + 1;
			end else begin
				// First start bit
				if (ones < PREAMBLE_BITS)
					flag($sformatf("only %0d preamble ones before the start code", ones));
				rx = '0;
				fidx = 1;
			end
		end else begin
			rx = {rx[30:0], mdio_in};
			fidx = fidx + 1;
			if (fidx == 14) begin
				rx_op = rx[11:10];
				rx_phy = rx[9:5];
				rx_reg = rx[4:0];
				reading = (rx_op == mdio_pkg::OP_READ) && (rx_phy == MY_ADDR);
				if (rx[13:12] != mdio_pkg::ST_CODE)
					flag($sformatf("start code was %b instead of 01", rx[13:12]));
				if (rx_op != (exp_write ? mdio_pkg::OP_WRITE : mdio_pkg::OP_READ))
					flag($sformatf("opcode %b does not match the request", rx_op));
				if (rx_phy != exp_phy_addr)
					flag($sformatf("PHY address %0d, request asked for %0d", rx_phy, exp_phy_addr));
				if (rx_reg != exp_reg_addr)
					flag($sformatf("register %0d, request asked for %0d", rx_reg, exp_reg_addr));
			end
			// Station owns the turnaround on writes
			if (fidx == 16 && rx_op == mdio_pkg::OP_WRITE && rx[1:0] != mdio_pkg::TA_WRITE)
				flag($sformatf("write turnaround was %b instead of 10", rx[1:0]));
			if (fidx == 32) begin
				if (rx_op == mdio_pkg::OP_WRITE && rx_phy == MY_ADDR) begin
					regs[rx_reg] = rx[15:0];
					written[rx_reg] = 1'b1;
				end
				frames = frames + 8'd1;
				reading = 1'b0;
				fidx = 0;
				ones = 0;
			end
		end
	end

	////////////////////
	// Drive on MDC falling edges

	always @(negedge mdc) begin
		if (reading && fidx == 15) begin
			// Second turnaround bit
			phy_oe = 1'b1;
			phy_out = 1'b0;
			tx = written[rx_reg] ? regs[rx_reg] : {11'b0, rx_reg};
		end else if (reading && fidx >= 16) begin
			phy_out = tx[mdio_pkg::DATA_W-1];
			tx = tx << 1;
		end else begin
			phy_oe = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/mdio_sta.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_sta #(
	// core_clk cycles per MDC half period
	parameter int CLK_DIV = 4,
	// Leading ones before the start code
	parameter int PREAMBLE_BITS = 32
) (
	input wire core_clk,
	input wire rst_n,

	// Host request
	input wire cmd_req,
	input wire cmd_write,
	input wire [mdio_pkg::ADDR_W-1:0] cmd_phy_addr,
	input wire [mdio_pkg::ADDR_W-1:0] cmd_reg_addr,
	input wire [mdio_pkg::DATA_W-1:0] cmd_wdata,

	// Host response
	output logic cmd_ack,
	output logic [mdio_pkg::DATA_W-1:0] rsp_rdata,
	output logic rsp_error,

	// Management bus with the inout split for the board top
	output logic mdc,
	output logic mdio_out,
	output logic mdio_oe,
	input wire mdio_in
);

	////////////////////
	// Stage links

	logic [mdio_pkg::FRAME_W-1:0] frame_word;
	logic frame_is_read;
	logic frame_start;
	logic rd_bit;
	logic rd_bit_valid;
	mdio_pkg::engine_state_t engine_state;
	logic xfer_done;

	// Request to frame word
	mdio_frame_decode u_decode (
		.core_clk      (core_clk),
		.rst_n         (rst_n),
		.cmd_req       (cmd_req),
		.cmd_write     (cmd_write),
		.cmd_phy_addr  (cmd_phy_addr),
		.cmd_reg_addr  (cmd_reg_addr),
		.cmd_wdata     (cmd_wdata),
		.xfer_done     (xfer_done),
		.frame_word    (frame_word),
		.frame_is_read (frame_is_read),
		.frame_start   (frame_start)
	);

	// Bus timing
	mdio_frame_engine #(
		.CLK_DIV       (CLK_DIV),
		.PREAMBLE_BITS (PREAMBLE_BITS)
	) u_engine (
		.core_clk      (core_clk),
		.rst_n         (rst_n),
		.frame_word    (frame_word),
		.frame_is_read (frame_is_read),
		.frame_start   (frame_start),
		.mdio_in       (mdio_in),
		.mdc           (mdc),
		.mdio_out      (mdio_out),
		.mdio_oe       (mdio_oe),
		.rd_bit        (rd_bit),
		.rd_bit_valid  (rd_bit_valid),
		.engine_state  (engine_state)
	);

	// Response and handshake
	mdio_read_result u_result (
		.core_clk     (core_clk),
		.rst_n        (rst_n),
		.cmd_req      (cmd_req),
		.rd_bit       (rd_bit),
		.rd_bit_valid (rd_bit_valid),
		.engine_state (engine_state),
		.cmd_ack      (cmd_ack),
		.rsp_rdata    (rsp_rdata),
		.rsp_error    (rsp_error),
		.xfer_done    (xfer_done)
	);

endmodule

`default_nettype wire

/* rtl/mdio_read_result.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_read_result (
	input wire core_clk,
	input wire rst_n,

	// Host side
	input wire cmd_req,

	// From the frame engine
	input wire rd_bit,
	input wire rd_bit_valid,
	input wire mdio_pkg::engine_state_t engine_state,

	// Response
	output logic cmd_ack,
	output logic [mdio_pkg::DATA_W-1:0] rsp_rdata,
	output logic rsp_error,

	// Rearms decode
	output logic xfer_done
);

	// TA bit in the MSB with data below it
	logic [mdio_pkg::DATA_W:0] rd_shift;
	// Read bits seen during this frame
	logic rd_seen;
	logic frame_done;

	assign frame_done = (engine_state == mdio_pkg::DONE);

	////////////////////
	// Handshake and error

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			cmd_ack <= 1'b0;
			rsp_error <= 1'b0;
			xfer_done <= 1'b0;
			rd_seen <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			if (rd_bit_valid)
				rd_seen <= 1'b1;

			if (frame_done) begin
				cmd_ack <= 1'b1;
				rd_seen <= 1'b0;
				// Pulled-up TA means no PHY drove the line
				rsp_error <= rd_seen && rd_shift[mdio_pkg::DATA_W];
			end else if (cmd_ack && !cmd_req) begin
				// Host has dropped req
				cmd_ack <= 1'b0;
				xfer_done <= 1'b1;
			end
		end
	end

	////////////////////
	// Read data

	always_ff @(posedge core_clk) begin
		if (rd_bit_valid)
			rd_shift <= {rd_shift[mdio_pkg::DATA_W-1:0], rd_bit};

		// Held until the next frame completes
		if (frame_done) begin
			if (!rd_seen)
				rsp_rdata <= '0;
			else if (rd_shift[mdio_pkg::DATA_W])
				rsp_rdata <= '1;
			else
				rsp_rdata <= rd_shift[mdio_pkg::DATA_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* rtl/mdio_frame_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_frame_engine #(
	parameter int CLK_DIV = 4,
	parameter int PREAMBLE_BITS = 32
) (
	input wire core_clk,
	input wire rst_n,

	// Frame from decode
	input wire [mdio_pkg::FRAME_W-1:0] frame_word,
	input wire frame_is_read,
	input wire frame_start,

	// Management bus
	input wire mdio_in,
	output logic mdc,
	output logic mdio_out,
	output logic mdio_oe,

	// Sampled read bits and state for the result stage
	output logic rd_bit,
	output logic rd_bit_valid,
	output mdio_pkg::engine_state_t engine_state
);

	localparam int TOTAL_BITS = PREAMBLE_BITS + mdio_pkg::FRAME_W;
	localparam int CNT_W = $clog2(TOTAL_BITS + 1);
	localparam int DIV_W = $clog2(CLK_DIV);
	// First turnaround bit follows ST, OP and both addresses
	localparam int TA_IDX = PREAMBLE_BITS + 4 + 2 * mdio_pkg::ADDR_W;

	logic [DIV_W-1:0] div_cnt;
	// Index of the bit on the bus counting the preamble
	logic [CNT_W-1:0] bit_cnt;
	logic [mdio_pkg::FRAME_W-1:0] shreg;
	// One cycle after an MDC falling edge
	logic fall_d;
	logic active;
	logic half_end;
	logic rise_tick;
	logic fall_tick;
	logic last_bit;

	////////////////////
	// MDC edge detect

	assign active = (engine_state == mdio_pkg::PREAMBLE) || (engine_state == mdio_pkg::SHIFT);
	assign half_end = active && (div_cnt == DIV_W'(CLK_DIV - 1));
	// Edge ticks line up with the cycle mdc toggles
	assign rise_tick = half_end && !mdc;
	assign fall_tick = half_end && mdc;
	assign last_bit = (bit_cnt == CNT_W'(TOTAL_BITS - 1));

	////////////////////
	// Control FSM

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			engine_state <= mdio_pkg::IDLE;
			mdc <= 1'b0;
			mdio_out <= 1'b1;
			mdio_oe <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			fall_d <= 1'b0;
			rd_bit_valid <= 1'b0;
		end else begin
			// No bit change after the last falling edge
			fall_d <= fall_tick && !last_bit;
			// Read bits from the second turnaround bit on
			rd_bit_valid <= rise_tick && frame_is_read && (bit_cnt >= CNT_W'(TA_IDX + 1));

			case (engine_state)
				mdio_pkg::IDLE: begin
					if (frame_start) begin
						engine_state <= (PREAMBLE_BITS == 0) ? mdio_pkg::SHIFT
							: mdio_pkg::PREAMBLE;
						mdc <= 1'b0;
						div_cnt <= '0;
						bit_cnt <= '0;
						mdio_oe <= 1'b1;
						// First bit on the line right away
						mdio_out <= (PREAMBLE_BITS == 0) ? frame_word[mdio_pkg::FRAME_W-1]
							: 1'b1;
					end
				end

				mdio_pkg::PREAMBLE, mdio_pkg::SHIFT: begin
					// Half period divider
					if (half_end) begin
						div_cnt <= '0;
						mdc <= ~mdc;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end

					// Bit boundary on the falling edge
					if (fall_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							engine_state <= mdio_pkg::DONE;
							mdio_oe <= 1'b0;
						end
					end

					// Drive the next bit a cycle later
					if (fall_d) begin
						if (bit_cnt == CNT_W'(PREAMBLE_BITS))
							engine_state <= mdio_pkg::SHIFT;
						mdio_out <= (bit_cnt < CNT_W'(PREAMBLE_BITS)) ? 1'b1
							: shreg[mdio_pkg::FRAME_W-1];
						// Hand the line to the PHY for TA and data
						if (frame_is_read && bit_cnt == CNT_W'(TA_IDX))
							mdio_oe <= 1'b0;
					end
				end

				// DONE lasts a single cycle
				default: begin
					engine_state <= mdio_pkg::IDLE;
				end
			endcase
		end
	end

	////////////////////
	// Frame shifter and sampler

	always_ff @(posedge core_clk) begin
		if (engine_state == mdio_pkg::IDLE && frame_start) begin
			// Without a preamble the MSB is already on the bus
			shreg <= (PREAMBLE_BITS == 0) ? (frame_word << 1) : frame_word;
		end else if (fall_d && bit_cnt >= CNT_W'(PREAMBLE_BITS)) begin
			shreg <= shreg << 1;
		end

		// PHY data is stable across the rising edge
		if (rise_tick)
			rd_bit <= mdio_in;
	end

endmodule

`default_nettype wire

/* rtl/mdio_frame_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_frame_decode (
	input wire core_clk,
	input wire rst_n,

	// Host request
	input wire cmd_req,
	input wire cmd_write,
	input wire [mdio_pkg::ADDR_W-1:0] cmd_phy_addr,
	input wire [mdio_pkg::ADDR_W-1:0] cmd_reg_addr,
	input wire [mdio_pkg::DATA_W-1:0] cmd_wdata,

	// Handshake closed by the result stage
	input wire xfer_done,

	// To the frame engine
	output logic [mdio_pkg::FRAME_W-1:0] frame_word,
	output logic frame_is_read,
	output logic frame_start
);

	// Set from acceptance until the handshake has closed
	logic busy;
	logic accept;
	logic [1:0] op_code;
	logic [mdio_pkg::DATA_W-1:0] data_field;

	////////////////////
	// Request acceptance

	// New request only while idle
	// xfer_done wins so a still-high req is not served twice
	assign accept = cmd_req && !busy && !xfer_done;

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			// Single-cycle start strobe
			frame_start <= 1'b0;
			if (xfer_done) begin
				busy <= 1'b0;
			end else if (accept) begin
				busy <= 1'b1;
				frame_start <= 1'b1;
			end
		end
	end

	////////////////////
	// Frame word

	assign op_code = cmd_write ? mdio_pkg::OP_WRITE : mdio_pkg::OP_READ;
	// Read frames carry zeros in place of the PHY's data bits
	assign data_field = cmd_write ? cmd_wdata : '0;

	// Latched once per access and held until the next acceptance
	always_ff @(posedge core_clk) begin
		if (accept) begin
			frame_is_read <= !cmd_write;
			frame_word <= {mdio_pkg::ST_CODE, op_code, cmd_phy_addr, cmd_reg_addr,
				mdio_pkg::TA_WRITE, data_field};
		end
	end

endmodule

`default_nettype wire

/* rtl/mdio_pkg.sv */
`default_nettype none

package mdio_pkg;

	////////////////////
	// Clause-22 frame fields

	// Start of frame
	localparam logic [1:0] ST_CODE = 2'b01;

	// Opcodes
	localparam logic [1:0] OP_WRITE = 2'b01;
	localparam logic [1:0] OP_READ = 2'b10;

	// Turnaround driven by the station on writes
	localparam logic [1:0] TA_WRITE = 2'b10;

	////////////////////
	// Field widths

	// PHY and register address
	localparam int ADDR_W = 5;
	// Register data
	localparam int DATA_W = 16;
	// ST + OP + PHYAD + REGAD + TA + DATA
	localparam int FRAME_W = 32;

	////////////////////
	// Frame engine states

	// IDLE     bus quiet, mdc parked low
	// PREAMBLE leading ones
	// SHIFT    frame bits, MSB first
	// DONE     one cycle, seen by the result stage
	typedef enum logic [1:0] {
		IDLE,
		PREAMBLE,
		SHIFT,
		DONE
	} engine_state_t;

endpackage

`default_nettype wire
